// File: rtl/aes_pkg.sv
// ========================================
// AES-128 only. Byte 0 sits in bits 127:120 as in FIPS-197
// S-boxes are built from GF(2^8) inversion, so they are deep logic
// ========================================

package aes_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [127:0] block_t;
	typedef logic [3:0] round_idx_t;

	localparam int NUM_ROUNDS = 10;

	// Multiply by x modulo x^8 + x^4 + x^3 + x + 1
	function automatic byte_t gf_mul2(byte_t a);
		return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic byte_t gf_mul(byte_t a, byte_t b);
		byte_t p;
		byte_t x;
		int i;
		p = 8'h00;
		x = a;
		for (i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = gf_mul2(x);
		end
		return p;
	endfunction

	// x^254 is the multiplicative inverse, and zero maps to zero
	function automatic byte_t gf_inv(byte_t x);
		byte_t sq;
		byte_t acc;
		int i;
		sq = x;
		acc = 8'h01;
		for (i = 1; i < 8; i++)
		begin
			sq = gf_mul(sq, sq);
			acc = gf_mul(acc, sq);
		end
		return acc;
	endfunction

	function automatic byte_t sub_byte(byte_t x);
		byte_t y;
		y = gf_inv(x);
		return y ^ {y[6:0], y[7]} ^ {y[5:0], y[7:6]} ^ {y[4:0], y[7:5]}
			^ {y[3:0], y[7:4]} ^ 8'h63;
	endfunction

	// Undo the affine map first, then invert
	function automatic byte_t inv_sub_byte(byte_t x);
		byte_t y;
		y = {x[6:0], x[7]} ^ {x[4:0], x[7:5]} ^ {x[1:0], x[7:2]} ^ 8'h05;
		return gf_inv(y);
	endfunction

	// Row r moves right by r columns
	function automatic block_t inv_shift_rows(block_t b);
		block_t r;
		int c;
		int row;
		int src;
		r = b;
		for (c = 0; c < 4; c++)
		begin
			for (row = 0; row < 4; row++)
			begin
				src = row + 4 * ((c - row + 4) % 4);
				r[127 - 8 * (row + 4 * c) -: 8] = b[127 - 8 * src -: 8];
			end
		end
		return r;
	endfunction

	// Circulant matrix 0e 0b 0d 09
	function automatic word_t inv_mix_column(word_t w);
		byte_t a [4];
		word_t r;
		int i;
		for (i = 0; i < 4; i++)
			a[i] = w[31 - 8 * i -: 8];
		for (i = 0; i < 4; i++)
		begin
			r[31 - 8 * i -: 8] = gf_mul(a[i], 8'h0e)
				^ gf_mul(a[(i + 1) % 4], 8'h0b)
				^ gf_mul(a[(i + 2) % 4], 8'h0d)
				^ gf_mul(a[(i + 3) % 4], 8'h09);
		end
		return r;
	endfunction

	function automatic word_t rot_sub_word(word_t w);
		word_t r;
		r = {w[23:0], w[31:24]};
		return {sub_byte(r[31:24]), sub_byte(r[23:16]), sub_byte(r[15:8]),
			sub_byte(r[7:0])};
	endfunction

endpackage

// File: rtl/key_store_if.sv
// ========================================
// Write side is a plain strobe, read side is combinational
// ========================================

interface key_store_if;

	logic wr_en;
	aes_pkg::round_idx_t wr_round;
	aes_pkg::block_t wr_key;
	aes_pkg::round_idx_t rd_round;
	aes_pkg::block_t rd_key;

	modport expander (
		output wr_en,
		output wr_round,
		output wr_key
	);

	modport store (
		input wr_en,
		input wr_round,
		input wr_key,
		input rd_round,
		output rd_key
	);

	modport cipher (
		output rd_round,
		input rd_key
	);

endinterface

// File: rtl/key_expander.sv
// ========================================
// Starts on a start level that was low at the previous edge
// Writes rounds 0 to 10 on eleven consecutive edges
// ========================================

module key_expander (
	input  logic CLK,
	input  logic RESET,
	input  logic start,
	input  aes_pkg::block_t key,
	output logic keys_ready,
	key_store_if.expander ks
);

	typedef enum logic {
		exp_idle,
		exp_run
	} expand_state_e;

	expand_state_e state;
	aes_pkg::round_idx_t round;
	aes_pkg::block_t words;
	aes_pkg::byte_t rcon;
	aes_pkg::word_t temp;
	aes_pkg::block_t next_words;
	logic start_q;
	logic launch;

	// A held start after done must not trigger a second expansion
	assign launch = (state == exp_idle) && start && !start_q;

	always_comb
	begin
		temp = aes_pkg::rot_sub_word(words[31:0]) ^ {rcon, 24'h000000};
		next_words[127:96] = words[127:96] ^ temp;
		next_words[95:64] = words[95:64] ^ next_words[127:96];
		next_words[63:32] = words[63:32] ^ next_words[95:64];
		next_words[31:0] = words[31:0] ^ next_words[63:32];
	end

	// Round 0 is the cipher key itself
	assign ks.wr_en = launch || (state == exp_run);
	assign ks.wr_round = launch ? 4'd0 : round;
	assign ks.wr_key = launch ? key : next_words;

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state <= exp_idle;
			round <= 4'd0;
			keys_ready <= 1'b0;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= start;
			if (launch)
			begin
				state <= exp_run;
				round <= 4'd1;
				keys_ready <= 1'b0;
			end
			else if (state == exp_run)
			begin
				round <= round + 4'd1;
				if (round == aes_pkg::NUM_ROUNDS)
				begin
					state <= exp_idle;
					keys_ready <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (launch)
		begin
			words <= key;
			rcon <= 8'h01;
		end
		else if (state == exp_run)
		begin
			words <= next_words;
			rcon <= aes_pkg::gf_mul2(rcon);
		end
	end

endmodule

// File: rtl/round_key_store.sv
// ========================================
// Eleven round keys, no reset on the array
// Only entries 0 to 10 are ever addressed
// ========================================

module round_key_store (
	input logic CLK,
	key_store_if.store ks
);

	aes_pkg::block_t keys [0:aes_pkg::NUM_ROUNDS];

	always_ff @(posedge CLK)
	begin
		if (ks.wr_en)
			keys[ks.wr_round] <= ks.wr_key;
	end

	// Zero latency read for AddRoundKey
	assign ks.rd_key = keys[ks.rd_round];

endmodule

// File: rtl/inv_cipher.sv
// ========================================
// One step per clock, InvMixColumns one column per cycle
// Starts only from idle, done holds until start drops
// ========================================

module inv_cipher (
	input  logic CLK,
	input  logic RESET,
	input  logic start,
	input  aes_pkg::block_t msg_enc,
	input  logic keys_ready,
	output logic done,
	output aes_pkg::block_t msg_dec,
	key_store_if.cipher ks
);

	typedef enum logic [3:0] {
		s_idle,
		s_wait_keys,
		s_init_add,
		s_shift,
		s_sub,
		s_add_key,
		s_mix0,
		s_mix1,
		s_mix2,
		s_mix3,
		s_final_shift,
		s_final_sub,
		s_final_add,
		s_done
	} cipher_state_e;

	cipher_state_e state;
	cipher_state_e nxt;
	aes_pkg::round_idx_t round;
	aes_pkg::block_t blk;
	aes_pkg::block_t blk_next;
	aes_pkg::block_t sub_out;
	aes_pkg::word_t mix_in;
	aes_pkg::word_t mix_out;
	logic [1:0] col;
	logic mixing;

	always_comb
	begin
		for (int i = 0; i < 16; i++)
			sub_out[127 - 8 * i -: 8] = aes_pkg::inv_sub_byte(blk[127 - 8 * i -: 8]);
	end

	// Column 0 is the top word of the block
	always_comb
	begin
		mixing = 1'b1;
		col = 2'd0;
		case (state)
			s_mix0: col = 2'd0;
			s_mix1: col = 2'd1;
			s_mix2: col = 2'd2;
			s_mix3: col = 2'd3;
			default: mixing = 1'b0;
		endcase
		mix_in = blk[127 - 32 * int'(col) -: 32];
		mix_out = aes_pkg::inv_mix_column(mix_in);
	end

	always_comb
	begin
		nxt = state;
		blk_next = blk;
		if (mixing)
			blk_next[127 - 32 * int'(col) -: 32] = mix_out;
		case (state)
			s_idle:
			begin
				if (start)
				begin
					nxt = s_wait_keys;
					blk_next = msg_enc;
				end
			end
			s_wait_keys:
			begin
				if (keys_ready)
					nxt = s_init_add;
			end
			s_init_add:
			begin
				blk_next = blk ^ ks.rd_key;
				nxt = s_shift;
			end
			s_shift:
			begin
				blk_next = aes_pkg::inv_shift_rows(blk);
				nxt = s_sub;
			end
			s_sub:
			begin
				blk_next = sub_out;
				nxt = s_add_key;
			end
			s_add_key:
			begin
				blk_next = blk ^ ks.rd_key;
				nxt = s_mix0;
			end
			s_mix0: nxt = s_mix1;
			s_mix1: nxt = s_mix2;
			s_mix2: nxt = s_mix3;
			s_mix3: nxt = (round == 4'd1) ? s_final_shift : s_shift;
			s_final_shift:
			begin
				blk_next = aes_pkg::inv_shift_rows(blk);
				nxt = s_final_sub;
			end
			s_final_sub:
			begin
				blk_next = sub_out;
				nxt = s_final_add;
			end
			s_final_add:
			begin
				blk_next = blk ^ ks.rd_key;
				nxt = s_done;
			end
			s_done:
			begin
				if (!start)
					nxt = s_idle;
			end
			default: nxt = s_idle;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state <= s_idle;
			round <= 4'd0;
		end
		else
		begin
			state <= nxt;
			if (state == s_idle && start)
				round <= aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS);
			else if (state == s_init_add || state == s_mix3)
				round <= round - 4'd1;
		end
	end

	always_ff @(posedge CLK)
		blk <= blk_next;

	// Round counter doubles as the key store address
	assign ks.rd_round = round;
	assign done = (state == s_done);
	assign msg_dec = done ? blk : '0;

endmodule

// File: rtl/aes_decrypt.sv
// ========================================
// AES-128 decryption, level start and held done
// Keys are expanded again on every operation
// ========================================

module aes_decrypt (
	input  logic CLK,
	input  logic RESET,
	input  logic start,
	input  aes_pkg::block_t key,
	input  aes_pkg::block_t msg_enc,
	output logic done,
	output aes_pkg::block_t msg_dec
);

	logic keys_ready;

	key_store_if ks ();

	key_expander u_expander (
		.CLK        (CLK),
		.RESET      (RESET),
		.start      (start),
		.key        (key),
		.keys_ready (keys_ready),
		.ks         (ks.expander)
	);

	round_key_store u_store (
		.CLK (CLK),
		.ks  (ks.store)
	);

	inv_cipher u_cipher (
		.CLK        (CLK),
		.RESET      (RESET),
		.start      (start),
		.msg_enc    (msg_enc),
		.keys_ready (keys_ready),
		.done       (done),
		.msg_dec    (msg_dec),
		.ks         (ks.cipher)
	);

endmodule

// File: testbench/aes_decrypt_assertions.sv
// ========================================
// Bound to the top level, sampled on the rising clock edge
// ========================================

module aes_decrypt_assertions (
	input logic CLK,
	input logic RESET,
	input logic start,
	input logic done,
	input aes_pkg::block_t msg_dec
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Plaintext is only visible while done is high
	dec_zero_when_idle: assert property (@(posedge CLK) disable iff (RESET)
		!done |-> msg_dec == '0)
	else
	begin
		$error("msg_dec is not zero while done is low");
		fail_count++;
	end

	done_falls_after_start_low: assert property (@(posedge CLK) disable iff (RESET)
		$fell(done) |-> !$past(start))
	else
	begin
		$error("done fell although start was high");
		fail_count++;
	end

	done_low_after_reset: assert property (@(posedge CLK) RESET |=> !done)
	else
	begin
		$error("done is high in the cycle after reset");
		fail_count++;
	end

endmodule

bind aes_decrypt aes_decrypt_assertions u_assertions (
	.CLK     (CLK),
	.RESET   (RESET),
	.start   (start),
	.done    (done),
	.msg_dec (msg_dec)
);

// File: testbench/aes_decrypt_tb.sv
// ========================================
// Directed tests with published AES-128 vectors
// Outputs are sampled on the falling clock edge
// ========================================

module aes_decrypt_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT = 170;
	// Nine operations of about 82 cycles, plus the hold and reset gaps
	localparam int MAX_CYCLES = 1000;
	// Falling edges counted from the start drive until done is seen
	// One for the drive, 11 key wait, 1 initial, 63 middle, 3 final, 1 done
	localparam int OP_CYCLES = 1 + 11 + 1 + 63 + 3 + 1;

	// FIPS-197 Appendix C.1
	localparam aes_pkg::block_t KEY_C1 = 128'h000102030405060708090a0b0c0d0e0f;
	localparam aes_pkg::block_t CT_C1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam aes_pkg::block_t PT_C1 = 128'h00112233445566778899aabbccddeeff;
	// FIPS-197 Appendix B
	localparam aes_pkg::block_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam aes_pkg::block_t CT_B = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam aes_pkg::block_t PT_B = 128'h3243f6a8885a308d313198a2e0370734;
	// All-zero key and plaintext
	localparam aes_pkg::block_t KEY_ZERO = 128'h0;
	localparam aes_pkg::block_t CT_ZERO = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
	localparam aes_pkg::block_t PT_ZERO = 128'h0;

	logic CLK;
	logic RESET;
	logic start;
	aes_pkg::block_t key;
	aes_pkg::block_t msg_enc;
	logic done;
	aes_pkg::block_t msg_dec;

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	aes_decrypt UUT (
		.CLK     (CLK),
		.RESET   (RESET),
		.start   (start),
		.key     (key),
		.msg_enc (msg_enc),
		.done    (done),
		.msg_dec (msg_dec)
	);

	initial
		CLK = 1'b0;

	always #50 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check_block(input aes_pkg::block_t actual, input aes_pkg::block_t expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR at %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR at %0t: %s is %b, expected %b", $time, what, actual, expected);
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("ERR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic start_op(input aes_pkg::block_t k, input aes_pkg::block_t ct);
		@(posedge CLK);
		key <= k;
		msg_enc <= ct;
		start <= 1'b1;
	endtask

	// Counts falling edges from the start drive until done is seen
	task automatic wait_done(output int cycles);
		cycles = 0;
		do
		begin
			@(negedge CLK);
			cycles++;
		end
		while (!done && cycles < WAIT_LIMIT);
		if (!done)
		begin
			errors++;
			$display("done did not rise within %0d cycles of start", WAIT_LIMIT);
		end
	endtask

	// Core sees start low one edge after the drive and idles on the next
	task automatic release_start();
		@(posedge CLK);
		start <= 1'b0;
		@(negedge CLK);
		check_bit(done, 1'b1, "done before start low is seen");
		@(negedge CLK);
		check_bit(done, 1'b0, "done after start drop");
		check_block(msg_dec, '0, "msg_dec after start drop");
	endtask

	task automatic decrypt_and_check(input aes_pkg::block_t k, input aes_pkg::block_t ct,
		input aes_pkg::block_t pt, input string what);
		int cycles;
		start_op(k, ct);
		wait_done(cycles);
		check_block(msg_dec, pt, what);
		check_count(cycles, OP_CYCLES, "latency");
		release_start();
	endtask

	task automatic test_appendix_c1();
		decrypt_and_check(KEY_C1, CT_C1, PT_C1, "appendix C.1 plaintext");
	endtask

	task automatic test_appendix_b();
		decrypt_and_check(KEY_B, CT_B, PT_B, "appendix B plaintext");
	endtask

	task automatic test_zero_key();
		decrypt_and_check(KEY_ZERO, CT_ZERO, PT_ZERO, "zero key plaintext");
	endtask

	task automatic test_hold_done();
		int cycles;
		int i;
		start_op(KEY_B, CT_B);
		wait_done(cycles);
		check_block(msg_dec, PT_B, "plaintext before hold");
		check_count(cycles, OP_CYCLES, "latency before hold");
		for (i = 0; i < 20; i++)
		begin
			@(negedge CLK);
			check_bit(done, 1'b1, "done while start held");
			check_block(msg_dec, PT_B, "msg_dec while start held");
		end
		release_start();
		decrypt_and_check(KEY_C1, CT_C1, PT_C1, "plaintext after hold");
	endtask

	// Different order than the first pass, so each key follows a different one
	task automatic test_back_to_back();
		decrypt_and_check(KEY_ZERO, CT_ZERO, PT_ZERO, "back to back zero key");
		decrypt_and_check(KEY_C1, CT_C1, PT_C1, "back to back C.1");
		decrypt_and_check(KEY_B, CT_B, PT_B, "back to back B");
	endtask

	task automatic test_reset_mid_op();
		int i;
		start_op(KEY_ZERO, CT_ZERO);
		for (i = 0; i < 30; i++)
			@(negedge CLK);
		@(posedge CLK);
		RESET <= 1'b1;
		start <= 1'b0;
		for (i = 0; i < 4; i++)
		begin
			@(negedge CLK);
			check_bit(done, 1'b0, "done during reset");
		end
		@(posedge CLK);
		RESET <= 1'b0;
		// Runs past the point where the aborted operation would have finished
		for (i = 0; i < 50; i++)
		begin
			@(negedge CLK);
			check_bit(done, 1'b0, "done after mid-op reset");
			check_block(msg_dec, '0, "msg_dec after mid-op reset");
		end
		decrypt_and_check(KEY_B, CT_B, PT_B, "plaintext after reset");
	endtask

	initial
	begin
		RESET = 1'b1;
		start = 1'b0;
		key = '0;
		msg_enc = '0;
		repeat (4) @(posedge CLK);
		RESET <= 1'b0;
		@(negedge CLK);
		check_bit(done, 1'b0, "done after reset");
		check_block(msg_dec, '0, "msg_dec after reset");

		test_appendix_c1();
		test_appendix_b();
		test_zero_key();
		test_hold_done();
		test_back_to_back();
		test_reset_mid_op();

		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, UUT.u_assertions.fail_count);
		if (errors == 0 && UUT.u_assertions.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sim.f
rtl/aes_pkg.sv
rtl/key_store_if.sv
rtl/key_expander.sv
rtl/round_key_store.sv
rtl/inv_cipher.sv
rtl/aes_decrypt.sv
testbench/aes_decrypt_assertions.sv
testbench/aes_decrypt_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = aes_decrypt_tb
FILELIST = sim.f
PASS_MSG = *** PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
